// ==== flash_reader.sv ====
`timescale 1ns/100ps

module flash_reader import ipod_pkg::*; (
  input  logic                    CLK_50M,
  input  logic                    reset,
  word_req_if.server              word_bus,
  output logic                    flash_read,
  output logic [FLASH_ADDR_W-1:0] flash_address,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  logic [FLASH_DATA_W-1:0] flash_readdata
);

  logic [1:0] state;

  // Read strobe straight from the state register
  assign flash_read = (state == FR_ADDR);

  // ====================================================================
  // Transaction FSM
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      state         <= FR_IDLE;
      word_bus.done <= 1'b0;
    end
    else
    begin
      word_bus.done <= 1'b0;
      case (state)
        FR_IDLE:
        begin
          // Requester still shows req in the done cycle
          if (word_bus.req && !word_bus.done)
            state <= FR_ADDR;
        end
        FR_ADDR:
        begin
          if (!flash_waitrequest)           // Read accepted
            state <= FR_WAIT;
        end
        FR_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            word_bus.done <= 1'b1;
            state         <= FR_IDLE;
          end
        end
        default: state <= FR_IDLE;
      endcase
    end
  end

  // Address and data capture
  always_ff @(posedge CLK_50M)
  begin
    if (state == FR_IDLE && word_bus.req)
      flash_address <= word_bus.addr;
    if (state == FR_WAIT && flash_readdatavalid)
      word_bus.data <= flash_readdata;
  end

endmodule

// ==== ipod_asserts.sv ====
`timescale 1ns/100ps

module ipod_asserts import ipod_pkg::*; (
  input logic                    CLK_50M,
  input logic                    reset,
  input logic                    flash_read,
  input logic [FLASH_ADDR_W-1:0] flash_address,
  input logic                    flash_waitrequest,
  input logic                    flash_readdatavalid,
  input logic                    sample_valid
);

  logic outstanding;                                 // Accepted read awaiting data

  always @(posedge CLK_50M)
  begin
    if (reset)
      outstanding <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      outstanding <= 1'b1;
    else if (flash_readdatavalid)
      outstanding <= 1'b0;
  end

  // Read held with a steady address while the flash stalls
  a_read_hold: assert property (@(posedge CLK_50M) disable iff (reset)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("flash_read dropped or address moved before acceptance");

  a_single_read: assert property (@(posedge CLK_50M) disable iff (reset)
    outstanding |-> !flash_read)
    else $error("new flash read issued while one is outstanding");

  a_reset_quiet: assert property (@(posedge CLK_50M)
    reset |=> !sample_valid)
    else $error("sample_valid high during reset");

endmodule

bind ipod_top ipod_asserts i_ipod_asserts (.*);

// ==== ipod_golden.txt ====
# op  arg(hex)  value(dec)  test_name
# key: arg ASCII code. speed: arg 1 up, 2 down, 3 reset, value repeat count
# expect_div: value is rate_divider. wait_samples: value samples, or arg quiet DIV_MAX periods
expect_div 0 1136 reset_divider
wait_samples 3 0 idle_before_start
speed 1 1 -
expect_div 0 1072 speed_up_once
speed 2 2 -
expect_div 0 1200 speed_down_twice
speed 1 20 -
expect_div 0 256 clamp_min
speed 3 1 -
expect_div 0 1136 speed_reset_from_min
speed 2 60 -
expect_div 0 4096 clamp_max
speed 3 1 -
expect_div 0 1136 speed_reset_from_max
speed 1 14 -
expect_div 0 256 fast_rate
key 45 0 -
wait_samples 0 20 forward_from_zero
key 42 0 -
wait_samples 0 10 backward_steps
key 46 0 -
wait_samples 0 10 forward_again
key 58 0 -
wait_samples 0 4 ignore_other_key
key 44 0 -
wait_samples 4 0 quiet_after_stop
key 45 0 -
wait_samples 0 6 resume_after_stop
key 52 0 -
wait_samples 0 5 restart_forward
key 42 0 -
wait_samples 0 10 backward_wrap
key 52 0 -
wait_samples 0 5 restart_backward
key 46 0 -
wait_samples 0 5 forward_wrap
speed 3 1 -
expect_div 0 1136 final_divider

// ==== ipod_pkg.sv ====
package ipod_pkg;

  // ====================================================================
  // Flash port
  // ====================================================================
  localparam int FLASH_ADDR_W = 23;                        // Word address
  localparam int FLASH_DATA_W = 32;
  localparam logic [FLASH_ADDR_W-1:0] LAST_WORD_ADDR = 23'h7FFFF; // End of song

  // Flash reader FSM encodings
  localparam logic [1:0] FR_IDLE = 2'd0;
  localparam logic [1:0] FR_ADDR = 2'd1;                   // read held until accepted
  localparam logic [1:0] FR_WAIT = 2'd2;                   // waiting on readdatavalid

  // ====================================================================
  // Samples
  // ====================================================================
  localparam int SAMPLE_W = 8;
  localparam int BYTES_PER_WORD = 4;
  localparam int BYTE_IDX_W = $clog2(BYTES_PER_WORD);
  localparam logic [BYTE_IDX_W-1:0] LAST_BYTE = BYTE_IDX_W'(BYTES_PER_WORD - 1);

  // ====================================================================
  // Sample rate divider
  // ====================================================================
  localparam int DIV_W = 16;
  localparam logic [DIV_W-1:0] DIV_DEFAULT = 16'd1136;     // About 44 kHz at 50 MHz
  localparam logic [DIV_W-1:0] DIV_STEP = 16'd64;
  localparam logic [DIV_W-1:0] DIV_MIN = 16'd256;          // Fastest rate
  localparam logic [DIV_W-1:0] DIV_MAX = 16'd4096;         // Slowest rate

  // ====================================================================
  // Keyboard commands (upper case ASCII)
  // ====================================================================
  localparam logic [7:0] KEY_START = 8'h45;                // E
  localparam logic [7:0] KEY_STOP = 8'h44;                 // D
  localparam logic [7:0] KEY_FWD = 8'h46;                  // F
  localparam logic [7:0] KEY_BACK = 8'h42;                 // B
  localparam logic [7:0] KEY_RESTART = 8'h52;              // R

endpackage

// ==== ipod_top.sv ====
`timescale 1ns/100ps

module ipod_top import ipod_pkg::*; (
  input  logic                    CLK_50M,
  input  logic                    reset,
  input  logic [7:0]              key_ascii,
  input  logic                    key_valid,
  input  logic                    speed_up,
  input  logic                    speed_down,
  input  logic                    speed_reset,
  output logic                    flash_read,
  output logic [FLASH_ADDR_W-1:0] flash_address,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  logic [FLASH_DATA_W-1:0] flash_readdata,
  output logic [SAMPLE_W-1:0]     sample,
  output logic                    sample_valid,
  output logic [DIV_W-1:0]        rate_divider
);

  logic tick;
  logic playing;

  word_req_if i_word_bus ();

  // ====================================================================
  // Rate control
  // ====================================================================
  rate_regs i_rate_regs (
    .CLK_50M     (CLK_50M),
    .reset       (reset),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .divider     (rate_divider)
  );

  sample_timer i_sample_timer (
    .CLK_50M (CLK_50M),
    .reset   (reset),
    .run     (playing),                     // Timer runs only during playback
    .divider (rate_divider),
    .tick    (tick)
  );

  // ====================================================================
  // Playback path
  // ====================================================================
  playback_sequencer i_playback_sequencer (
    .CLK_50M      (CLK_50M),
    .reset        (reset),
    .key_ascii    (key_ascii),
    .key_valid    (key_valid),
    .tick         (tick),
    .word_bus     (i_word_bus.requester),
    .playing      (playing),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  flash_reader i_flash_reader (
    .CLK_50M             (CLK_50M),
    .reset               (reset),
    .word_bus            (i_word_bus.server),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata)
  );

endmodule

// ==== playback_sequencer.sv ====
`timescale 1ns/100ps

module playback_sequencer import ipod_pkg::*; (
  input  logic                CLK_50M,
  input  logic                reset,
  input  logic [7:0]          key_ascii,
  input  logic                key_valid,
  input  logic                tick,
  word_req_if.requester       word_bus,
  output logic                playing,
  output logic [SAMPLE_W-1:0] sample,
  output logic                sample_valid
);

  logic                    dir_back;        // 0 forward, 1 backward
  logic                    restart;
  logic                    started;         // Last position already played
  logic [FLASH_ADDR_W-1:0] last_addr;
  logic [BYTE_IDX_W-1:0]   last_byte;
  logic [FLASH_ADDR_W-1:0] next_addr;
  logic [BYTE_IDX_W-1:0]   next_byte;
  logic                    word_valid;
  logic [FLASH_ADDR_W-1:0] held_addr;
  logic [FLASH_DATA_W-1:0] word_data;
  logic                    tick_pending;
  logic                    service;
  logic                    hit;

  assign restart = key_valid && (key_ascii == KEY_RESTART);

  // ====================================================================
  // Command decoding
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      playing  <= 1'b0;
      dir_back <= 1'b0;
    end
    else if (key_valid)
    begin
      case (key_ascii)
        KEY_START: playing <= 1'b1;
        KEY_STOP:  playing <= 1'b0;
        KEY_FWD:   dir_back <= 1'b0;
        KEY_BACK:  dir_back <= 1'b1;
        default: ;                          // Restart acts on the position
      endcase
    end
  end

  // ====================================================================
  // Next sample position
  // ====================================================================
  always_comb
  begin
    next_addr = last_addr;
    next_byte = last_byte;
    if (started)
    begin
      if (!dir_back)
      begin
        if (last_byte == LAST_BYTE)
        begin
          next_byte = '0;
          next_addr = (last_addr == LAST_WORD_ADDR) ? '0 : last_addr + 1'b1;
        end
        else
          next_byte = last_byte + 1'b1;
      end
      else
      begin
        if (last_byte == '0)
        begin
          next_byte = LAST_BYTE;
          next_addr = (last_addr == '0) ? LAST_WORD_ADDR : last_addr - 1'b1;
        end
        else
          next_byte = last_byte - 1'b1;
      end
    end
  end

  assign service = playing && (tick || tick_pending);
  assign hit     = word_valid && (held_addr == next_addr);  // Held word has it

  // ====================================================================
  // Playback control and word fetch
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      last_addr    <= '0;
      last_byte    <= '0;
      started      <= 1'b0;
      word_valid   <= 1'b0;
      tick_pending <= 1'b0;
      word_bus.req <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      if (word_bus.done)
      begin
        word_valid   <= 1'b1;
        word_bus.req <= 1'b0;
      end

      if (service)
      begin
        if (hit)
        begin
          sample_valid <= 1'b1;
          last_addr    <= next_addr;
          last_byte    <= next_byte;
          started      <= 1'b1;
          tick_pending <= 1'b0;
        end
        else
        begin
          tick_pending <= 1'b1;             // Extra ticks fold into this one
          if (!word_bus.req)
            word_bus.req <= 1'b1;
        end
      end
      else if (!playing)
        tick_pending <= 1'b0;

      // Start point of the current direction
      if (restart)
      begin
        last_addr  <= dir_back ? LAST_WORD_ADDR : '0;
        last_byte  <= dir_back ? LAST_BYTE : '0;
        started    <= 1'b0;
        word_valid <= 1'b0;
      end
    end
  end

  // Word, address and sample registers
  always_ff @(posedge CLK_50M)
  begin
    if (word_bus.done)
    begin
      word_data <= word_bus.data;
      held_addr <= word_bus.addr;           // Tag for the held word
    end
    if (service && !hit && !word_bus.req)
      word_bus.addr <= next_addr;
    if (service && hit)
      sample <= word_data[next_byte*SAMPLE_W +: SAMPLE_W];
  end

endmodule

// ==== rate_regs.sv ====
`timescale 1ns/100ps

module rate_regs import ipod_pkg::*; (
  input  logic             CLK_50M,
  input  logic             reset,
  input  logic             speed_up,
  input  logic             speed_down,
  input  logic             speed_reset,
  output logic [DIV_W-1:0] divider
);

  logic [DIV_W-1:0] div_faster;
  logic [DIV_W-1:0] div_slower;

  // ====================================================================
  // Clamped candidates for the next divider
  // ====================================================================
  always_comb
  begin
    // Smaller divider gives a higher sample rate
    if (divider <= DIV_MIN + DIV_STEP)
      div_faster = DIV_MIN;
    else
      div_faster = divider - DIV_STEP;

    if (divider >= DIV_MAX - DIV_STEP)
      div_slower = DIV_MAX;
    else
      div_slower = divider + DIV_STEP;
  end

  // ====================================================================
  // Divider register
  // ====================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      divider <= DIV_DEFAULT;
    end
    else if (speed_reset)                   // Wins over up and down
    begin
      divider <= DIV_DEFAULT;
    end
    else if (speed_up && !speed_down)
    begin
      divider <= div_faster;
    end
    else if (speed_down && !speed_up)
    begin
      divider <= div_slower;
    end
    // Both at once cancel out
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator, then search the log for the failure line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sim.f -o tb_sim \
  > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }

// ==== sample_timer.sv ====
`timescale 1ns/100ps

module sample_timer import ipod_pkg::*; (
  input  logic             CLK_50M,
  input  logic             reset,
  input  logic             run,
  input  logic [DIV_W-1:0] divider,
  output logic             tick
);

  logic [DIV_W-1:0] count;
  logic [DIV_W-1:0] div_q;                  // Last divider seen

  // Counts divider-1 down to 0 so the period is divider cycles
  always_ff @(posedge CLK_50M)
  begin
    if (reset)
    begin
      count <= DIV_DEFAULT - DIV_W'(1);
      div_q <= DIV_DEFAULT;
      tick  <= 1'b0;
    end
    else
    begin
      div_q <= divider;
      tick  <= 1'b0;
      if (!run || divider != div_q)         // Hold or restart on rate change
      begin
        count <= divider - DIV_W'(1);
      end
      else if (count == '0)
      begin
        tick  <= 1'b1;
        count <= divider - DIV_W'(1);
      end
      else
      begin
        count <= count - DIV_W'(1);
      end
    end
  end

endmodule

// ==== sim.f ====
ipod_pkg.sv
word_req_if.sv
flash_reader.sv
rate_regs.sv
sample_timer.sv
playback_sequencer.sv
ipod_top.sv
tb_clock.sv
tb_checker.sv
ipod_asserts.sv
tb_top.sv

// ==== tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker import ipod_pkg::*; (
  input logic                CLK_50M,
  input logic                reset,
  input logic [7:0]          key_ascii,
  input logic                key_valid,
  input logic [SAMPLE_W-1:0] sample,
  input logic                sample_valid,
  input logic [DIV_W-1:0]    rate_divider
);

  // Byte position of the last sample in the song
  localparam int unsigned POS_LAST = BYTES_PER_WORD * (int'(LAST_WORD_ADDR) + 1) - 1;

  int unsigned last_pos;
  bit          started;
  bit          dir_back;
  bit          key_q_valid;
  logic [7:0]  key_q;
  int unsigned nxt_pos;
  logic [7:0]  exp_sample;

  string cur_name = "none";
  bit    test_fail;
  int    sample_count;
  int    error_count;
  int    test_count;
  int    failed_count;
  int    checked_count;

  initial
  begin
    error_count   = 0;
    test_count    = 0;
    failed_count  = 0;
    checked_count = 0;
    sample_count  = 0;
    test_fail     = 0;
  end

  // ====================================================================
  // Reference model of the play position
  // ====================================================================
  always @(posedge CLK_50M)
  begin
    if (reset)
    begin
      last_pos    = 0;
      started     = 0;
      dir_back    = 0;
      key_q_valid = 0;
    end
    else
    begin
      // Sample was chosen one cycle ago, before the key of that cycle acted
      if (sample_valid)
      begin
        if (!started)
          nxt_pos = last_pos;
        else if (dir_back)
          nxt_pos = (last_pos == 0) ? POS_LAST : last_pos - 1;
        else
          nxt_pos = (last_pos == POS_LAST) ? 0 : last_pos + 1;
        exp_sample = nxt_pos[7:0];                   // Flash byte equals position mod 256
        if (sample !== exp_sample)
        begin
          $display("FAIL %s: expected 0x%02h, actual 0x%02h", cur_name, exp_sample, sample);
          error_count++;
          test_fail = 1;
        end
        last_pos = nxt_pos;
        started  = 1;
        sample_count++;
        checked_count++;
      end

      if (key_q_valid)
      begin
        case (key_q)
          KEY_FWD:  dir_back = 0;
          KEY_BACK: dir_back = 1;
          KEY_RESTART:
          begin
            last_pos = dir_back ? POS_LAST : 0;
            started  = 0;
          end
          default: ;
        endcase
      end
      key_q_valid = key_valid;
      key_q       = key_ascii;
    end
  end

  // ====================================================================
  // Test bookkeeping
  // ====================================================================
  task automatic start_test(input string name);
    cur_name     = name;
    test_fail    = 0;
    sample_count = 0;
  endtask

  task automatic check_div(input int expected);
    if (rate_divider !== DIV_W'(expected))
    begin
      $display("FAIL %s: expected %0d, actual %0d", cur_name, expected, rate_divider);
      error_count++;
      test_fail = 1;
    end
  endtask

  task automatic check_count(input int expected);
    if (sample_count != expected)
    begin
      $display("FAIL %s: expected %0d samples, actual %0d", cur_name, expected, sample_count);
      error_count++;
      test_fail = 1;
    end
  endtask

  task automatic count_error();
    error_count++;
  endtask

  task automatic end_test();
    test_count++;
    if (test_fail)
    begin
      failed_count++;
      $display("%s: failed", cur_name);
    end
    else
      $display("%s: ok", cur_name);
  endtask

  task automatic report();
    $display("%0d tests, %0d failed, %0d samples checked, %0d errors",
             test_count, failed_count, checked_count, error_count);
  endtask

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
  output logic CLK_50M,
  output logic reset
);

  // 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // Two cycles of reset, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    reset = 1'b0;
  end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/100ps

module tb_top import ipod_pkg::*; ();

  logic                    CLK_50M;
  logic                    reset;
  logic [7:0]              key_ascii;
  logic                    key_valid;
  logic                    speed_up;
  logic                    speed_down;
  logic                    speed_reset;
  logic                    flash_read;
  logic [FLASH_ADDR_W-1:0] flash_address;
  logic                    flash_waitrequest;
  logic                    flash_readdatavalid;
  logic [FLASH_DATA_W-1:0] flash_readdata;
  logic [SAMPLE_W-1:0]     sample;
  logic                    sample_valid;
  logic [DIV_W-1:0]        rate_divider;

  string op_q[$];
  int    arg_q[$];
  int    val_q[$];
  string name_q[$];
  int    watchdog_cycles;
  bit    watchdog_armed = 0;

  tb_clock i_tb_clock (.CLK_50M(CLK_50M), .reset(reset));

  ipod_top i_ipod_top (.*);

  tb_checker i_checker (.*);

  // ====================================================================
  // Flash model
  // ====================================================================
  function automatic logic [FLASH_DATA_W-1:0] flash_word(input logic [FLASH_ADDR_W-1:0] a);
    logic [FLASH_DATA_W-1:0] w;
    for (int k = 0; k < 4; k++)
      w[8*k +: 8] = 8'((4 * int'(a) + k) % 256);   // Byte 0 in the low lane
    return w;
  endfunction

  bit                      busy = 0;
  int                      lat;
  logic [FLASH_ADDR_W-1:0] rd_addr;

  always @(negedge CLK_50M)
  begin
    flash_readdatavalid <= 1'b0;
    if (busy)
    begin
      if (lat <= 1)
      begin
        flash_readdatavalid <= 1'b1;
        flash_readdata      <= flash_word(rd_addr);
        busy = 0;
      end
      else
        lat = lat - 1;
      flash_waitrequest <= 1'b1;
    end
    else if (flash_read)
    begin
      if ($urandom_range(0, 2) == 0)               // Random stall
        flash_waitrequest <= 1'b1;
      else
      begin
        flash_waitrequest <= 1'b0;
        rd_addr = flash_address;
        lat     = $urandom_range(1, 3);
        busy    = 1;
      end
    end
    else
      flash_waitrequest <= 1'b1;
  end

  // ====================================================================
  // Golden file and operations
  // ====================================================================
  task automatic load_golden(output bit ok);
    int    fd;
    int    n;
    string line;
    string op;
    string name;
    int    arg;
    int    val;
    ok = 0;
    fd = $fopen("ipod_golden.txt", "r");
    if (fd != 0)
    begin
      ok = 1;
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 2 && line.getc(0) != "#")
        begin
          if ($sscanf(line, "%s %h %d %s", op, arg, val, name) == 4)
          begin
            op_q.push_back(op);
            arg_q.push_back(arg);
            val_q.push_back(val);
            name_q.push_back(name);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic pulse_speed(input int kind);
    @(negedge CLK_50M);
    speed_up    = (kind == 1);
    speed_down  = (kind == 2);
    speed_reset = (kind == 3);
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  task automatic send_key(input logic [7:0] code);
    @(negedge CLK_50M);
    key_ascii = code;
    key_valid = 1'b1;
    @(negedge CLK_50M);
    key_valid = 1'b0;
  endtask

  task automatic run_op(input int i);
    if (op_q[i] == "key")
      send_key(8'(arg_q[i]));
    else if (op_q[i] == "speed")
    begin
      repeat (val_q[i]) pulse_speed(arg_q[i]);
    end
    else if (op_q[i] == "expect_div")
    begin
      @(negedge CLK_50M);
      i_checker.start_test(name_q[i]);
      i_checker.check_div(val_q[i]);
      i_checker.end_test();
    end
    else if (op_q[i] == "wait_samples" && val_q[i] == 0)
    begin
      repeat (2) @(negedge CLK_50M);               // Let a sample already chosen drain
      i_checker.start_test(name_q[i]);
      repeat (arg_q[i] * int'(DIV_MAX)) @(negedge CLK_50M);
      i_checker.check_count(0);
      i_checker.end_test();
    end
    else if (op_q[i] == "wait_samples")
    begin
      i_checker.start_test(name_q[i]);
      while (i_checker.sample_count < val_q[i])
        @(negedge CLK_50M);
      i_checker.end_test();
    end
    else
    begin
      $display("Unknown operation %s in golden file", op_q[i]);
      i_checker.count_error();
    end
  endtask

  // Time budget from the sample counts and quiet periods in the file
  function automatic int budget_cycles();
    int total;
    total = 2000;
    foreach (op_q[i])
    begin
      if (op_q[i] == "wait_samples")
        total += val_q[i] * int'(DIV_MAX) * 4 + arg_q[i] * int'(DIV_MAX);
      else
        total += 10 * (val_q[i] > 0 && op_q[i] == "speed" ? val_q[i] : 1);
    end
    return total;
  endfunction

  initial
  begin
    bit ok;
    void'($urandom(40128));
    key_ascii           = 8'h00;
    key_valid           = 1'b0;
    speed_up            = 1'b0;
    speed_down          = 1'b0;
    speed_reset         = 1'b0;
    flash_waitrequest   = 1'b1;
    flash_readdatavalid = 1'b0;
    flash_readdata      = '0;
    load_golden(ok);
    if (!ok || op_q.size() == 0)
    begin
      $display("Could not read any operation from ipod_golden.txt");
      $display("Test failed");
      $finish;
    end
    else
    begin
      watchdog_cycles = budget_cycles();
      watchdog_armed  = 1;
      @(negedge CLK_50M);
      while (reset)
        @(negedge CLK_50M);
      foreach (op_q[i])
        run_op(i);
      i_checker.report();
      if (i_checker.error_count == 0)
        $display("Test passed");
      else
        $display("Test failed");
      $finish;
    end
  end

  // Watchdog
  initial
  begin
    wait (watchdog_armed);
    repeat (watchdog_cycles) @(posedge CLK_50M);
    $display("Timeout after %0d cycles, the DUT stopped delivering samples", watchdog_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== word_req_if.sv ====
`timescale 1ns/100ps

interface word_req_if import ipod_pkg::*; ();

  logic req;                                // Held high until done
  logic [FLASH_ADDR_W-1:0] addr;            // Stable while req is high
  logic done;                               // Single cycle
  logic [FLASH_DATA_W-1:0] data;            // Valid with done

  // Sequencer side
  modport requester (
    output req,
    output addr,
    input  done,
    input  data
  );

  // Flash reader side
  modport server (
    input  req,
    input  addr,
    output done,
    output data
  );

endinterface
